// ==== list.f ====
+incdir+logic
logic/exec_pkg.sv
logic/issue_if.sv
logic/alu.sv
logic/credit_counter.sv
logic/issue_ctrl.sv
logic/exec_unit.sv
logic/exec_top.sv
dv/exec_assertions.sv
dv/tb_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_exec -f list.f -o tb_exec

sim_out="$(./obj_dir/tb_exec)"
echo "$sim_out"

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// ==== dv/tb_exec.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module tb_exec;
    import exec_pkg::*;

    typedef struct packed {
        word_t      pc;
        exec_kind_t kind;
        alu_op_t    op;
        word_t      src1;
        word_t      src2;
        word_t      imm;
        word_t      csr_data;
        logic       src1_is_pc;
        logic       src2_is_imm;
        reg_idx_t   rd;
    } issue_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
        word_t    csr_wdata;
        logic     redir;
        word_t    target;
    } exp_t;

    localparam int    TOTAL_OPS      = 40 + 30 + 16 + 3 * `EXEC_CREDITS + 10 + 60;
    localparam int    TIMEOUT_CYCLES = 20 * TOTAL_OPS + 1000;
    localparam word_t SIGN_BIT       = word_t'(1) << (`EXEC_XLEN - 1);
    localparam word_t ALL_ONES       = '1;

    logic       clk;
    logic       rst;
    logic       issue_valid;
    word_t      issue_pc;
    exec_kind_t issue_kind;
    alu_op_t    issue_op;
    word_t      issue_src1;
    word_t      issue_src2;
    word_t      issue_imm;
    word_t      issue_csr_data;
    logic       issue_src1_is_pc;
    logic       issue_src2_is_imm;
    reg_idx_t   issue_rd;
    logic       issue_ready;
    logic       credit_return;
    logic       res_valid;
    reg_idx_t   res_rd;
    word_t      res_value;
    word_t      res_csr_wdata;
    logic       redirect_valid;
    word_t      redirect_pc;

    exp_t exp_q[$];
    int   cyc = 0;
    int   errors = 0;
    int   issued = 0;
    int   returned = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   branch_sel = 0;
    logic hold_credits;
    logic fence_wait;

    exec_top i_dut (
        .clk               (clk),
        .rst               (rst),
        .issue_valid       (issue_valid),
        .issue_pc          (issue_pc),
        .issue_kind        (issue_kind),
        .issue_op          (issue_op),
        .issue_src1        (issue_src1),
        .issue_src2        (issue_src2),
        .issue_imm         (issue_imm),
        .issue_csr_data    (issue_csr_data),
        .issue_src1_is_pc  (issue_src1_is_pc),
        .issue_src2_is_imm (issue_src2_is_imm),
        .issue_rd          (issue_rd),
        .issue_ready       (issue_ready),
        .credit_return     (credit_return),
        .res_valid         (res_valid),
        .res_rd            (res_rd),
        .res_value         (res_value),
        .res_csr_wdata     (res_csr_wdata),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("timeout, run still busy after %0d cycles", cyc);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic exp_t ref_result(input issue_t t);
        exp_t       e;
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        logic       take;
        a    = t.src1_is_pc ? t.pc : t.src1;
        b    = t.src2_is_imm ? t.imm : t.src2;
        sh   = b[4:0];
        take = 1'b0;
        e    = '0;
        e.rd = t.rd;
        case (t.kind)
            KIND_ALU: begin
                case (t.op)
                    ALU_ADD:  e.value = a + b;
                    ALU_SUB:  e.value = a - b;
                    ALU_AND:  e.value = a & b;
                    ALU_OR:   e.value = a | b;
                    ALU_XOR:  e.value = a ^ b;
                    ALU_SLL:  e.value = a << sh;
                    ALU_SRL:  e.value = a >> sh;
                    ALU_SRA:  e.value = (a >> sh) | ((a & SIGN_BIT) != '0 ? ~(ALL_ONES >> sh) : '0);
                    ALU_SLT:  e.value = word_t'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
                    ALU_SLTU: e.value = word_t'(a < b);
                    default:  e.value = '0;
                endcase
            end
            KIND_JAL, KIND_JALR: begin
                e.value  = t.pc + 4;
                e.redir  = 1'b1;
                e.target = (t.kind == KIND_JAL) ? t.pc + t.imm : (t.src1 + t.imm) & ~word_t'(1);
            end
            KIND_BRANCH: begin
                case (t.op)
                    ALU_EQ:  take = (t.src1 == t.src2);
                    ALU_NE:  take = (t.src1 != t.src2);
                    ALU_LT:  take = ((t.src1 ^ SIGN_BIT) < (t.src2 ^ SIGN_BIT));
                    ALU_GE:  take = ((t.src1 ^ SIGN_BIT) >= (t.src2 ^ SIGN_BIT));
                    ALU_LTU: take = (t.src1 < t.src2);
                    default: take = (t.src1 >= t.src2);
                endcase
                e.redir  = take;
                e.target = t.pc + t.imm;
            end
            KIND_CSRRW, KIND_CSRRS: begin
                e.value     = t.csr_data;
                e.csr_wdata = (t.kind == KIND_CSRRW) ? t.src1 : (t.src1 | t.csr_data);
            end
            KIND_ECALL, KIND_MRET: begin
                e.redir  = 1'b1;
                e.target = t.csr_data;
            end
            default: e.value = '0;
        endcase
        return e;
    endfunction

    function automatic issue_t random_op(input exec_kind_t kind);
        issue_t t;
        t.pc          = word_t'($urandom()) & ~word_t'(3);
        t.kind        = kind;
        t.op          = alu_op_t'(4'($urandom_range(15, 0)));
        t.src1        = word_t'($urandom());
        t.src2        = word_t'($urandom());
        t.imm         = word_t'($urandom());
        t.csr_data    = word_t'($urandom());
        t.src1_is_pc  = 1'($urandom_range(1, 0));
        t.src2_is_imm = 1'($urandom_range(1, 0));
        t.rd          = reg_idx_t'($urandom_range(31, 0));
        // small signed offsets half of the time.
        if ($urandom_range(1, 0) == 0) begin
            t.imm = word_t'($urandom_range(64, 0)) - word_t'(32);
        end
        if (kind == KIND_ALU) begin
            t.op = alu_op_t'(4'($urandom_range(9, 0)));
        end
        if (kind == KIND_BRANCH) begin
            // step through the six compares in turn.
            t.op = alu_op_t'(4'(10 + branch_sel % 6));
            branch_sel++;
            if ($urandom_range(2, 0) == 0) begin
                t.src2 = t.src1;
            end
        end
        return t;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("Mismatch %s exp 0x%h got 0x%h", name, exp, got);
            errors++;
        end
    endtask

    task automatic drive_op(input issue_t t);
        issue_pc          = t.pc;
        issue_kind        = t.kind;
        issue_op          = t.op;
        issue_src1        = t.src1;
        issue_src2        = t.src2;
        issue_imm         = t.imm;
        issue_csr_data    = t.csr_data;
        issue_src1_is_pc  = t.src1_is_pc;
        issue_src2_is_imm = t.src2_is_imm;
        issue_rd          = t.rd;
        issue_valid       = 1'b1;
    endtask

    // called at a falling edge, returns at the next one.
    task automatic offer_op(input issue_t t, output bit accepted);
        drive_op(t);
        accepted = issue_ready;
        if (accepted) begin
            if (fence_wait) begin
                assert (issued == returned) else begin
                    $display("operation accepted with %0d credits still out after fence.i",
                             issued - returned);
                    errors++;
                end
            end
            fence_wait = (t.kind == KIND_FENCE_I);
            exp_q.push_back(ref_result(t));
            issued++;
        end
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic send_op(input issue_t t);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            offer_op(t, accepted);
        end
    endtask

    task automatic credit_model();
        int due_q[$];
        forever begin
            @(negedge clk);
            if (res_valid) begin
                due_q.push_back(cyc + int'($urandom_range(5, 0)));
            end
            credit_return = 1'b0;
            if (!hold_credits && due_q.size() != 0 && due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                credit_return = 1'b1;
                returned++;
            end
        end
    endtask

    task automatic result_checker();
        exp_t e;
        forever begin
            @(negedge clk);
            if (res_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("result seen with no operation outstanding");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    check_word("res_rd", word_t'(e.rd), word_t'(res_rd));
                    check_word("res_value", e.value, res_value);
                    check_word("res_csr_wdata", e.csr_wdata, res_csr_wdata);
                    check_word("redirect_valid", word_t'(e.redir), word_t'(redirect_valid));
                    if (e.redir) begin
                        check_word("redirect_pc", e.target, redirect_pc);
                    end
                end
            end else begin
                assert (!redirect_valid) else begin
                    $display("redirect_valid high without a result");
                    errors++;
                end
            end
        end
    endtask

    task automatic finish_test(input string name, input int start_err);
        while (exp_q.size() != 0 || issued != returned) begin
            @(negedge clk);
        end
        // let the counter and the drain state settle.
        repeat (2) @(negedge clk);
        if (errors == start_err) begin
            tests_passed++;
            $display("test %s done, no errors", name);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors", name, errors - start_err);
        end
    endtask

    task automatic test_kinds(input string name, input int n, input int lo, input int hi);
        int start_err;
        start_err = errors;
        for (int i = 0; i < n; i++) begin
            send_op(random_op(exec_kind_t'(4'($urandom_range(hi, lo)))));
        end
        finish_test(name, start_err);
    endtask

    task automatic test_backpressure();
        int start_err;
        int taken;
        bit accepted;
        start_err    = errors;
        taken        = 0;
        hold_credits = 1'b1;
        for (int i = 0; i < `EXEC_CREDITS + 4; i++) begin
            offer_op(random_op(KIND_ALU), accepted);
            taken += int'(accepted);
        end
        assert (taken == `EXEC_CREDITS) else begin
            $display("%0d operations accepted with credits withheld, %0d slots exist",
                     taken, `EXEC_CREDITS);
            errors++;
        end
        hold_credits = 1'b0;
        for (int i = 0; i < 2 * `EXEC_CREDITS; i++) begin
            send_op(random_op(KIND_ALU));
        end
        finish_test("backpressure", start_err);
    endtask

    task automatic test_fence();
        int start_err;
        start_err = errors;
        for (int r = 0; r < 2; r++) begin
            send_op(random_op(KIND_ALU));
            send_op(random_op(KIND_ALU));
            send_op(random_op(KIND_FENCE_I));
            send_op(random_op(KIND_ALU));
            send_op(random_op(KIND_ALU));
        end
        finish_test("fence_i", start_err);
    endtask

    initial begin
        void'($urandom(32'he632));
        clk          = 1'b0;
        rst          = 1'b1;
        hold_credits = 1'b0;
        fence_wait   = 1'b0;
        drive_op('0);
        issue_valid   = 1'b0;
        credit_return = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            credit_model();
            result_checker();
        join_none
        test_kinds("alu", 40, int'(KIND_ALU), int'(KIND_ALU));
        test_kinds("jump_branch", 30, int'(KIND_JAL), int'(KIND_BRANCH));
        test_kinds("csr_trap", 16, int'(KIND_CSRRW), int'(KIND_MRET));
        test_backpressure();
        test_fence();
        test_kinds("random_mix", 60, int'(KIND_ALU), int'(KIND_FENCE_I));
        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/exec_assertions.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_assertions (
    input logic                 clk,
    input logic                 rst,
    input exec_pkg::credit_t    count,
    input logic                 full,
    input logic                 issue_valid,
    input logic                 issue_ready,
    input exec_pkg::exec_kind_t issue_kind,
    input logic                 credit_return,
    input logic                 res_valid
);
    import exec_pkg::*;

    logic fire;
    logic draining;
    int   outstanding;

    assign fire = issue_valid & issue_ready;

    // high from an accepted fence.i until full is seen.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draining <= 1'b0;
        end else if (fire && (issue_kind == KIND_FENCE_I)) begin
            draining <= 1'b1;
        end else if (full) begin
            draining <= 1'b0;
        end
    end

    // results not yet returned downstream.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(fire) - int'(credit_return);
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= credit_t'(`EXEC_CREDITS))
        else $error("credit count above the number of slots");

    a_no_ready_empty: assert property (@(posedge clk) disable iff (rst)
        !(issue_ready && (outstanding >= `EXEC_CREDITS)))
        else $error("issue_ready high with every downstream slot taken");

    a_res_after_fire: assert property (@(posedge clk) disable iff (rst)
        fire |=> res_valid)
        else $error("accepted operation produced no result");

    a_no_res_without_fire: assert property (@(posedge clk) disable iff (rst)
        !fire |=> !res_valid)
        else $error("result without an accepted operation");

    a_fence_drain: assert property (@(posedge clk) disable iff (rst)
        draining |-> !issue_ready)
        else $error("issue_ready high during fence.i drain");

endmodule

bind exec_top exec_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .count         (count),
    .full          (full),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .issue_kind    (issue_kind),
    .credit_return (credit_return),
    .res_valid     (res_valid)
);

// ==== logic/exec_top.sv ====
`timescale 1ns/1ps

module exec_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  exec_pkg::word_t      issue_pc,
    input  exec_pkg::exec_kind_t issue_kind,
    input  exec_pkg::alu_op_t    issue_op,
    input  exec_pkg::word_t      issue_src1,
    input  exec_pkg::word_t      issue_src2,
    input  exec_pkg::word_t      issue_imm,
    input  exec_pkg::word_t      issue_csr_data,
    input  logic                 issue_src1_is_pc,
    input  logic                 issue_src2_is_imm,
    input  exec_pkg::reg_idx_t   issue_rd,
    output logic                 issue_ready,
    input  logic                 credit_return,
    output logic                 res_valid,
    output exec_pkg::reg_idx_t   res_rd,
    output exec_pkg::word_t      res_value,
    output exec_pkg::word_t      res_csr_wdata,
    output logic                 redirect_valid,
    output exec_pkg::word_t      redirect_pc
);
    import exec_pkg::*;

    credit_t count;
    logic    full;

    issue_if iss ();

    assign iss.valid       = issue_valid;
    assign iss.pc          = issue_pc;
    assign iss.kind        = issue_kind;
    assign iss.op          = issue_op;
    assign iss.src1        = issue_src1;
    assign iss.src2        = issue_src2;
    assign iss.imm         = issue_imm;
    assign iss.csr_data    = issue_csr_data;
    assign iss.src1_is_pc  = issue_src1_is_pc;
    assign iss.src2_is_imm = issue_src2_is_imm;
    assign iss.rd          = issue_rd;

    // one credit per accepted op.
    credit_counter u_credits (
        .clk       (clk),
        .rst       (rst),
        .spend     (iss.fire),
        .give_back (credit_return),
        .count     (count),
        .full      (full)
    );

    issue_ctrl u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .iss   (iss),
        .count (count),
        .full  (full),
        .ready (issue_ready)
    );

    exec_unit u_exec (
        .clk            (clk),
        .rst            (rst),
        .iss            (iss),
        .res_valid      (res_valid),
        .res_rd         (res_rd),
        .res_value      (res_value),
        .res_csr_wdata  (res_csr_wdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_unit (
    input  logic               clk,
    input  logic               rst,
    issue_if.datapath          iss,
    output logic               res_valid,
    output exec_pkg::reg_idx_t res_rd,
    output exec_pkg::word_t    res_value,
    output exec_pkg::word_t    res_csr_wdata,
    output logic               redirect_valid,
    output exec_pkg::word_t    redirect_pc
);
    import exec_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_value;
    logic  alu_cond;
    word_t link_pc;
    word_t rel_target;
    word_t jalr_target;
    word_t value_d;
    word_t csr_wdata_d;
    word_t target_d;
    logic  redirect_d;
    logic  is_branch;

    assign is_branch = (iss.kind == KIND_BRANCH);

    // branches compare the raw registers.
    assign op_a = (iss.src1_is_pc && !is_branch) ? iss.pc : iss.src1;
    assign op_b = (iss.src2_is_imm && !is_branch) ? iss.imm : iss.src2;

    alu u_alu (
        .op    (iss.op),
        .a     (op_a),
        .b     (op_b),
        .value (alu_value),
        .cond  (alu_cond)
    );

    assign link_pc     = iss.pc + `EXEC_XLEN'd4;
    assign rel_target  = iss.pc + iss.imm;
    assign jalr_target = (iss.src1 + iss.imm) & ~word_t'(1);

    always_comb begin
        value_d     = '0;
        csr_wdata_d = '0;
        target_d    = '0;
        redirect_d  = 1'b0;
        unique case (iss.kind)
            KIND_ALU: value_d = alu_value;
            KIND_JAL: begin
                value_d    = link_pc;
                redirect_d = 1'b1;
                target_d   = rel_target;
            end
            KIND_JALR: begin
                value_d    = link_pc;
                redirect_d = 1'b1;
                target_d   = jalr_target;
            end
            KIND_BRANCH: begin
                redirect_d = alu_cond;
                target_d   = alu_cond ? rel_target : '0;
            end
            KIND_CSRRW: begin
                value_d     = iss.csr_data;
                csr_wdata_d = iss.src1;
            end
            KIND_CSRRS: begin
                value_d     = iss.csr_data;
                csr_wdata_d = iss.src1 | iss.csr_data;
            end
            KIND_ECALL, KIND_MRET: begin
                redirect_d = 1'b1;
                target_d   = iss.csr_data;
            end
            default: value_d = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            res_valid      <= iss.fire;
            redirect_valid <= iss.fire & redirect_d;
        end
    end

    // payload, only loaded on an accepted op.
    always_ff @(posedge clk) begin
        if (iss.fire) begin
            res_rd        <= iss.rd;
            res_value     <= value_d;
            res_csr_wdata <= csr_wdata_d;
            redirect_pc   <= target_d;
        end
    end

endmodule

// ==== logic/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic              clk,
    input  logic              rst,
    issue_if.ctrl             iss,
    input  exec_pkg::credit_t count,
    input  logic              full,
    output logic              ready
);
    import exec_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        fence_fire;

    assign ready = (state == ST_RUN) && (count != '0);

    assign iss.fire = iss.valid & ready;

    assign fence_fire = iss.fire && (iss.kind == KIND_FENCE_I);

    always_comb begin
        state_next = state;
        unique case (state)
            ST_RUN: begin
                if (fence_fire) begin
                    state_next = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // wait for all credits.
                if (full) begin
                    state_next = ST_RUN;
                end
            end
            default: state_next = ST_RUN;
        endcase
    end

    // reset lands in drain, so ready rises once the full count is seen.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_DRAIN;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== logic/credit_counter.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module credit_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              spend,
    input  logic              give_back,
    output exec_pkg::credit_t count,
    output logic              full
);
    import exec_pkg::*;

    localparam credit_t CREDITS_MAX = credit_t'(`EXEC_CREDITS);

    // free downstream slots.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= CREDITS_MAX;
        end else begin
            unique case ({spend, give_back})
                2'b10:   count <= count - credit_t'(1);
                2'b01:   count <= count + credit_t'(1);
                default: count <= count;
            endcase
        end
    end

    // every result returned.
    assign full = (count == CREDITS_MAX);

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  exec_pkg::alu_op_t op,
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    output exec_pkg::word_t   value,
    output logic              cond
);
    import exec_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign eq    = (a == b);
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        value = '0;
        unique case (op)
            ALU_ADD:  value = a + b;
            ALU_SUB:  value = a - b;
            ALU_AND:  value = a & b;
            ALU_OR:   value = a | b;
            ALU_XOR:  value = a ^ b;
            ALU_SLL:  value = a << shamt;
            ALU_SRL:  value = a >> shamt;
            ALU_SRA:  value = word_t'($signed(a) >>> shamt);
            ALU_SLT:  value = word_t'(lt_s);
            ALU_SLTU: value = word_t'(lt_u);
            // compare ops leave value at zero.
            default:  value = '0;
        endcase
    end

    always_comb begin
        cond = 1'b0;
        unique case (op)
            ALU_EQ:  cond = eq;
            ALU_NE:  cond = ~eq;
            ALU_LT:  cond = lt_s;
            ALU_GE:  cond = ~lt_s;
            ALU_LTU: cond = lt_u;
            ALU_GEU: cond = ~lt_u;
            default: cond = 1'b0;
        endcase
    end

endmodule

// ==== logic/issue_if.sv ====
`timescale 1ns/1ps

interface issue_if;
    import exec_pkg::*;

    logic       valid;
    logic       fire;
    word_t      pc;
    exec_kind_t kind;
    alu_op_t    op;
    word_t      src1;
    word_t      src2;
    word_t      imm;
    word_t      csr_data;
    logic       src1_is_pc;
    logic       src2_is_imm;
    reg_idx_t   rd;

    // acceptance side.
    modport ctrl (input valid, input kind, output fire);

    modport datapath (
        input fire, input valid, input pc, input kind, input op,
        input src1, input src2, input imm, input csr_data,
        input src1_is_pc, input src2_is_imm, input rd
    );

endinterface

// ==== logic/exec_pkg.sv ====
`include "exec_config.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [3:0]            credit_t;

    typedef enum logic [3:0] {
        KIND_ALU     = 4'd0,
        KIND_JAL     = 4'd1,
        KIND_JALR    = 4'd2,
        KIND_BRANCH  = 4'd3,
        KIND_CSRRW   = 4'd4,
        KIND_CSRRS   = 4'd5,
        KIND_ECALL   = 4'd6,
        KIND_MRET    = 4'd7,
        KIND_FENCE_I = 4'd8
    } exec_kind_t;

    // all sixteen codes in use.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_EQ   = 4'd10,
        ALU_NE   = 4'd11,
        ALU_LT   = 4'd12,
        ALU_GE   = 4'd13,
        ALU_LTU  = 4'd14,
        ALU_GEU  = 4'd15
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_RUN   = 2'd0,
        ST_DRAIN = 2'd1
    } ctrl_state_t;

endpackage

// ==== logic/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// data and address width.
`define EXEC_XLEN 32

// downstream result slots, 1 to 15.
`define EXEC_CREDITS 4

`endif
